/* Makefile */
# Verilator build of the matrix adder testbench
# The binary exits nonzero when the run fails

SIM  := obj_dir/Vtb_matrix_fixed_adder
SRCS := $(shell cat list.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) list.f
	verilator --binary --timing --assert --top-module tb_matrix_fixed_adder -f list.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

/* credit_fifo.sv */
////////////////////////////////////////////////////////////
// Credit-guarded buffer, any packed payload via beat_t
// Upstream must hold a credit per beat, no overflow check
// Output is registered, one beat per cycle at most
// One in_credit pulse per slot freed
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module credit_fifo #(
  parameter type beat_t       = logic,
  parameter int  DEPTH        = 4,
  parameter int  DEST_CREDITS = 4
) (
  input  logic  CLK,
  input  logic  RST,

  // Upstream side
  input  logic  in_valid,
  input  beat_t in_beat,
  output logic  in_credit,

  // Downstream side
  output logic  out_valid,
  output beat_t out_beat,
  input  logic  out_credit
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam int KW = $clog2(DEST_CREDITS + 1);

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  beat_t         mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  // Credits held for the downstream receiver
  logic [KW-1:0] credits;

  logic          send;

  // Wrap at DEPTH, works for any depth
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    logic [AW-1:0] nxt;
    nxt = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // Oldest entry goes out when one is stored and a credit is held
  assign send = (count != '0) && (credits != '0);

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= KW'(DEST_CREDITS);
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (send) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Push and pop may meet in one cycle
      count     <= count + CW'(in_valid) - CW'(send);
      // Spend on send, regain on each returned pulse
      credits   <= credits - KW'(send) + KW'(out_credit);
      out_valid <= send;
      // Slot freed in the same cycle the beat leaves
      in_credit <= send;
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_beat;
    end
    if (send) begin
      out_beat <= mem[rd_ptr];
    end
  end

endmodule

/* fixed_add_stage.sv */
////////////////////////////////////////////////////////////
// Registered signed add or subtract with saturation
// Clamps to the most positive or most negative value
// and flags overflow, no rounding
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fixed_add_stage (
  input  logic                       CLK,
  input  logic                       RST,

  input  logic                       in_valid,
  input  matrix_add_pkg::walk_beat_t in_beat,

  output logic                       out_valid,
  output matrix_add_pkg::result_t    out_beat
);

  localparam int DS = matrix_add_pkg::DATA_SIZE;

  // Saturation limits
  localparam logic [DS-1:0] MAX_VAL = {1'b0, {(DS - 1){1'b1}}};
  localparam logic [DS-1:0] MIN_VAL = {1'b1, {(DS - 1){1'b0}}};

  logic [DS:0]   a_ext;
  logic [DS:0]   b_ext;
  logic [DS:0]   full;
  logic          overflow;
  logic [DS-1:0] clamped;

  // One guard bit, sign extended
  assign a_ext = {in_beat.pair.data_a[DS-1], in_beat.pair.data_a};
  assign b_ext = {in_beat.pair.data_b[DS-1], in_beat.pair.data_b};

  assign full = (in_beat.pair.operation == matrix_add_pkg::OP_SUB) ?
                a_ext - b_ext : a_ext + b_ext;

  // Guard bit differs from sign bit when out of range
  assign overflow = full[DS] ^ full[DS-1];

  // Guard bit is the sign of the true result
  assign clamped = !overflow ? full[DS-1:0] :
                   (full[DS] ? MIN_VAL : MAX_VAL);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      out_beat.data       <= clamped;
      out_beat.overflow   <= overflow;
      out_beat.end_row    <= in_beat.end_row;
      out_beat.end_matrix <= in_beat.end_matrix;
    end
  end

endmodule

/* list.f */
matrix_add_pkg.sv
credit_fifo.sv
matrix_walker.sv
fixed_add_stage.sv
matrix_fixed_adder.sv
matrix_fixed_adder_chk.sv
tb_matrix_fixed_adder.sv

/* matrix_add_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths and beat formats for the matrix adder
// Elements are two's complement, fraction point is implicit
// and never looked at, so any Qm.n split works unchanged
////////////////////////////////////////////////////////////

package matrix_add_pkg;

  // Width of one signed fixed-point element
  localparam int DATA_SIZE = 16;

  // Element operation, one bit
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } op_e;

  // One input element, 33 bits
  typedef struct packed {
    op_e                  operation;
    logic [DATA_SIZE-1:0] data_a;
    logic [DATA_SIZE-1:0] data_b;
  } op_pair_t;

  // Walker output, 35 bits
  // pair.operation holds the operation latched for the matrix
  typedef struct packed {
    op_pair_t pair;
    logic     end_row;
    logic     end_matrix;
  } walk_beat_t;

  // One output element, 19 bits
  typedef struct packed {
    logic [DATA_SIZE-1:0] data;
    logic                 overflow;
    logic                 end_row;
    logic                 end_matrix;
  } result_t;

endpackage

/* matrix_fixed_adder.sv */
////////////////////////////////////////////////////////////
// Streaming element-wise matrix add or subtract
// Credited links on both sides, source starts with
// IN_DEPTH credits and the sink grants OUT_DEPTH
// Operation and sizes are taken per matrix at element 0
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_fixed_adder #(
  parameter int IN_DEPTH     = 4,
  parameter int OUT_DEPTH    = 4,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                     CLK,
  input  logic                     RST,

  input  logic [CONTROL_SIZE-1:0]  size_i,
  input  logic [CONTROL_SIZE-1:0]  size_j,

  input  logic                     in_valid,
  input  matrix_add_pkg::op_pair_t in_beat,
  output logic                     in_credit,

  output logic                     out_valid,
  output matrix_add_pkg::result_t  out_beat,
  input  logic                     out_credit
);

  ////////////////////////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////////////////////////

  logic                       pair_valid;
  matrix_add_pkg::op_pair_t   pair_beat;
  logic                       walk_valid;
  matrix_add_pkg::walk_beat_t walk_beat;
  logic                       res_valid;
  matrix_add_pkg::result_t    res_beat;

  // Output buffer slot returns, spent by the input buffer
  logic                       res_credit;

  // Input buffer holds credits for the output buffer slots
  credit_fifo #(
    .beat_t      (matrix_add_pkg::op_pair_t),
    .DEPTH       (IN_DEPTH),
    .DEST_CREDITS(OUT_DEPTH)
  ) u_in_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_credit (in_credit),
    .out_valid (pair_valid),
    .out_beat  (pair_beat),
    .out_credit(res_credit)
  );

  matrix_walker #(
    .CONTROL_SIZE(CONTROL_SIZE)
  ) u_walker (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (pair_valid),
    .in_beat  (pair_beat),
    .size_i   (size_i),
    .size_j   (size_j),
    .out_valid(walk_valid),
    .out_beat (walk_beat)
  );

  fixed_add_stage u_add (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (walk_valid),
    .in_beat  (walk_beat),
    .out_valid(res_valid),
    .out_beat (res_beat)
  );

  credit_fifo #(
    .beat_t      (matrix_add_pkg::result_t),
    .DEPTH       (OUT_DEPTH),
    .DEST_CREDITS(OUT_DEPTH)
  ) u_out_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (res_valid),
    .in_beat   (res_beat),
    .in_credit (res_credit),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_credit(out_credit)
  );

endmodule

/* matrix_fixed_adder_chk.sv */
////////////////////////////////////////////////////////////
// Credit and reset checks on the top-level ports
// Counters restart with RST, so a mid-run reset is fine
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_fixed_adder_chk #(
  parameter int IN_DEPTH  = 4,
  parameter int OUT_DEPTH = 4
) (
  input logic CLK,
  input logic RST,
  input logic in_valid,
  input logic in_credit,
  input logic out_valid,
  input logic out_credit
);

  // Accepted input beats whose slot is not yet returned
  int in_pending;
  // Sink credits still held by the DUT
  int out_avail;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      in_pending <= 0;
      out_avail  <= OUT_DEPTH;
    end else begin
      in_pending <= in_pending + int'(in_valid) - int'(in_credit);
      out_avail  <= out_avail + int'(out_credit) - int'(out_valid);
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit accounting
  ////////////////////////////////////////////////////////////

  a_out_range: assert property (@(posedge CLK) disable iff (RST)
    out_avail >= 0 && out_avail <= OUT_DEPTH)
    else $error("DUT holds more or fewer sink credits than possible");

  a_out_send: assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> out_avail > 0)
    else $error("out_valid sent without an outstanding credit");

  a_in_range: assert property (@(posedge CLK) disable iff (RST)
    in_pending >= 0 && in_pending <= IN_DEPTH)
    else $error("Input credits returned do not match accepted beats");

  a_in_credit: assert property (@(posedge CLK) disable iff (RST)
    in_credit |-> in_pending > 0)
    else $error("in_credit pulsed with no beat held");

  // Quiet outputs in reset and just after
  a_reset_quiet: assert property (@(posedge CLK)
    RST |-> !in_credit && !out_valid)
    else $error("in_credit or out_valid high during reset");

  a_after_reset: assert property (@(posedge CLK)
    $fell(RST) |-> (!in_credit && !out_valid) ##1 (!in_credit && !out_valid))
    else $error("in_credit or out_valid high right after reset");

endmodule

bind matrix_fixed_adder matrix_fixed_adder_chk #(
  .IN_DEPTH (IN_DEPTH),
  .OUT_DEPTH(OUT_DEPTH)
) u_chk (.*);

/* matrix_walker.sv */
////////////////////////////////////////////////////////////
// Element position counter for a row-major matrix stream
// size_i and size_j must be nonzero and held stable from
// the first element of a matrix until its last
// Never stalls, one cycle from input to tagged beat
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_walker #(
  parameter int CONTROL_SIZE = 8
) (
  input  logic                           CLK,
  input  logic                           RST,

  input  logic                           in_valid,
  input  matrix_add_pkg::op_pair_t       in_beat,

  // Matrix sizes, rows and columns
  input  logic [CONTROL_SIZE-1:0]        size_i,
  input  logic [CONTROL_SIZE-1:0]        size_j,

  output logic                           out_valid,
  output matrix_add_pkg::walk_beat_t     out_beat
);

  // Current row and column
  logic [CONTROL_SIZE-1:0] index_i;
  logic [CONTROL_SIZE-1:0] index_j;

  // Per-matrix values taken at its first element
  logic [CONTROL_SIZE-1:0] size_i_lat;
  logic [CONTROL_SIZE-1:0] size_j_lat;
  matrix_add_pkg::op_e     op_lat;

  logic                    first;
  logic [CONTROL_SIZE-1:0] cur_size_i;
  logic [CONTROL_SIZE-1:0] cur_size_j;
  matrix_add_pkg::op_e     cur_op;
  logic                    last_col;
  logic                    last_row;

  ////////////////////////////////////////////////////////////
  // Position decode
  ////////////////////////////////////////////////////////////

  assign first      = (index_i == '0) && (index_j == '0);

  // Live values on the first element, latched ones after
  assign cur_size_i = first ? size_i : size_i_lat;
  assign cur_size_j = first ? size_j : size_j_lat;
  assign cur_op     = first ? in_beat.operation : op_lat;

  assign last_col   = (index_j == cur_size_j - CONTROL_SIZE'(1));
  assign last_row   = (index_i == cur_size_i - CONTROL_SIZE'(1));

  ////////////////////////////////////////////////////////////
  // Index and latch state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index_i    <= '0;
      index_j    <= '0;
      size_i_lat <= '0;
      size_j_lat <= '0;
      op_lat     <= matrix_add_pkg::OP_ADD;
      out_valid  <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        if (first) begin
          size_i_lat <= size_i;
          size_j_lat <= size_j;
          op_lat     <= in_beat.operation;
        end
        // Column steps every beat, row steps at row end
        if (last_col) begin
          index_j <= '0;
          index_i <= last_row ? '0 : index_i + CONTROL_SIZE'(1);
        end else begin
          index_j <= index_j + CONTROL_SIZE'(1);
        end
      end
    end
  end

  // Tagged beat, operation replaced by the matrix one
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      out_beat.pair           <= in_beat;
      out_beat.pair.operation <= cur_op;
      out_beat.end_row        <= last_col;
      out_beat.end_matrix     <= last_col && last_row;
    end
  end

endmodule

/* tb_matrix_fixed_adder.sv */
////////////////////////////////////////////////////////////
// Random operands, gaps and credit returns from seed 27
// A new matrix waits until earlier results have drained
// so the live sizes never change under a running matrix
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_matrix_fixed_adder;

  localparam int IN_DEPTH  = 4;
  localparam int OUT_DEPTH = 4;
  localparam int CS        = 8;
  localparam int DS        = matrix_add_pkg::DATA_SIZE;

  // 2x2 + 2x2 + 1x1 + 3x4 + 2x1 + 5x6
  localparam int TOTAL_BEATS = 53;
  localparam int CYCLE_LIMIT = TOTAL_BEATS * 40;

  logic                     CLK;
  logic                     RST;
  logic [CS-1:0]            size_i;
  logic [CS-1:0]            size_j;
  logic                     in_valid;
  matrix_add_pkg::op_pair_t in_beat;
  logic                     in_credit;
  logic                     out_valid;
  matrix_add_pkg::result_t  out_beat;
  logic                     out_credit = 1'b0;

  // Expected results in send order
  // checked indexes the next one to compare
  matrix_add_pkg::result_t  exp_q[$];
  int                       checked      = 0;
  int                       sent         = 0;
  int                       credits_back = 0;
  int                       returned     = 0;
  int                       cycles       = 0;
  logic                     hold_sink    = 1'b0;

  // Corner operands for the add matrix at 0 and the subtract matrix at 4
  logic [DS-1:0]            sat_a [8];
  logic [DS-1:0]            sat_b [8];

  matrix_fixed_adder #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_DEPTH   (OUT_DEPTH),
    .CONTROL_SIZE(CS)
  ) dut (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped");
  endtask

  // Saturating reference on full-range integers
  function automatic matrix_add_pkg::result_t expected_result(
    input logic [DS-1:0] a, input logic [DS-1:0] b,
    input matrix_add_pkg::op_e op, input logic er, input logic em);
    matrix_add_pkg::result_t r;
    int sum;
    int max_v;
    int min_v;
    max_v = (1 << (DS - 1)) - 1;
    min_v = -(1 << (DS - 1));
    if (op == matrix_add_pkg::OP_SUB) begin
      sum = int'($signed(a)) - int'($signed(b));
    end else begin
      sum = int'($signed(a)) + int'($signed(b));
    end
    r.overflow   = (sum > max_v) || (sum < min_v);
    r.data       = (sum > max_v) ? DS'(max_v) : (sum < min_v) ? DS'(min_v) : DS'(sum);
    r.end_row    = er;
    r.end_matrix = em;
    return r;
  endfunction

  task automatic check_field(input string name, input logic [DS-1:0] got,
                             input logic [DS-1:0] want);
    assert (got == want)
      else abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, want));
  endtask

  // Called on a falling edge
  // Waits for a credit and a random gap
  task automatic send_beat(input matrix_add_pkg::op_pair_t p);
    while (sent - credits_back >= IN_DEPTH || $urandom_range(3) == 0) begin
      @(negedge CLK);
    end
    in_valid = 1'b1;
    in_beat  = p;
    sent++;
    @(negedge CLK);
    in_valid = 1'b0;
  endtask

  // Negative corner gives random operands
  task automatic send_matrix(input int rows, input int cols,
                             input matrix_add_pkg::op_e op, input int corner);
    matrix_add_pkg::op_pair_t p;
    int   idx;
    logic er;
    logic em;
    while (checked != exp_q.size()) begin
      @(negedge CLK);
    end
    size_i = CS'(rows);
    size_j = CS'(cols);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        idx = r * cols + c;
        // Later elements carry a random operation that must be ignored
        if (idx == 0) begin
          p.operation = op;
        end else begin
          p.operation = ($urandom_range(1) == 1) ? matrix_add_pkg::OP_SUB :
                                                   matrix_add_pkg::OP_ADD;
        end
        p.data_a = (corner >= 0) ? sat_a[corner + idx] : DS'($urandom);
        p.data_b = (corner >= 0) ? sat_b[corner + idx] : DS'($urandom);
        er = (c == cols - 1);
        em = er && (r == rows - 1);
        exp_q.push_back(expected_result(p.data_a, p.data_b, op, er, em));
        send_beat(p);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitors and sink
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (in_credit) begin
      credits_back++;
    end
  end

  always @(posedge CLK) begin
    matrix_add_pkg::result_t exp_beat;
    if (!RST && out_valid) begin
      assert (checked < exp_q.size())
        else abort_run("out_valid fired with no result expected");
      exp_beat = exp_q[checked];
      check_field("out_beat.data", out_beat.data, exp_beat.data);
      check_field("out_beat.overflow", DS'(out_beat.overflow), DS'(exp_beat.overflow));
      check_field("out_beat.end_row", DS'(out_beat.end_row), DS'(exp_beat.end_row));
      check_field("out_beat.end_matrix", DS'(out_beat.end_matrix),
                  DS'(exp_beat.end_matrix));
      checked++;
    end
  end

  // One credit back per received result at random times
  always @(negedge CLK) begin
    if (!RST && !hold_sink && checked > returned && $urandom_range(2) != 0) begin
      out_credit = 1'b1;
      returned++;
    end else begin
      out_credit = 1'b0;
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout after %0d cycles, %0d of %0d results seen",
                          cycles, checked, TOTAL_BEATS));
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(27));
    RST      = 1'b1;
    in_valid = 1'b0;
    in_beat  = '0;
    size_i   = CS'(1);
    size_j   = CS'(1);
    sat_a = '{16'h7000, 16'h8000, 16'h0010, 16'hfffb,
              16'h7fff, 16'h8000, 16'h1234, 16'h0003};
    sat_b = '{16'h2000, 16'h9000, 16'h0020, 16'h0003,
              16'hffff, 16'h0001, 16'h0234, 16'h0005};
    repeat (8) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    // Both clamp directions and ordinary sums
    send_matrix(2, 2, matrix_add_pkg::OP_ADD, 0);
    send_matrix(2, 2, matrix_add_pkg::OP_SUB, 4);
    // Back-to-back sizes with alternating operations
    send_matrix(1, 1, matrix_add_pkg::OP_SUB, -1);
    send_matrix(3, 4, matrix_add_pkg::OP_ADD, -1);
    send_matrix(2, 1, matrix_add_pkg::OP_SUB, -1);
    // Stall starts with every result drained and every sink credit back
    while (checked != exp_q.size() || returned != checked) begin
      @(negedge CLK);
    end
    // Sink goes silent so both buffers fill
    @(posedge CLK);
    hold_sink = 1'b1;
    @(negedge CLK);
    fork
      send_matrix(5, 6, matrix_add_pkg::OP_ADD, -1);
      begin
        repeat (150) @(posedge CLK);
        hold_sink = 1'b0;
      end
    join
    while (checked != exp_q.size()) begin
      @(negedge CLK);
    end
    repeat (4) @(negedge CLK);
    if (checked == TOTAL_BEATS && sent == TOTAL_BEATS) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run($sformatf("Only %0d of %0d results arrived", checked, TOTAL_BEATS));
    end
  end

endmodule
